// File: hdl/ex_alu.sv
`include "ex_consts.svh"

module ex_alu (
  input  ex_pkg::alu_op_e operator_i,
  input  ex_pkg::word_t   operand_a_i,
  input  ex_pkg::word_t   operand_b_i,
  output ex_pkg::word_t   result_o,
  output logic            cmp_result_o
);

  // Shared adder, one extra bit on top for the compare sign
  logic               is_sub;
  logic               is_signed;
  logic [`EX_XLEN:0]  adder_a;
  logic [`EX_XLEN:0]  adder_b;
  logic [`EX_XLEN:0]  adder_sum;

  logic               is_lt;
  logic               is_eq;
  logic [4:0]         shamt;

  ////////////////////
  // Adder
  ////////////////////

  // Everything except ADD goes through the subtraction path
  assign is_sub = (operator_i != ex_pkg::ALU_ADD);

  // Signed compares extend with the sign bit, unsigned ones with zero
  assign is_signed = (operator_i == ex_pkg::ALU_SLT) ||
                     (operator_i == ex_pkg::ALU_LT)  ||
                     (operator_i == ex_pkg::ALU_GE);

  assign adder_a = {is_signed & operand_a_i[`EX_XLEN-1], operand_a_i};
  // Invert b and add the carry in for a - b
  assign adder_b = {is_signed & operand_b_i[`EX_XLEN-1], operand_b_i} ^ {(`EX_XLEN+1){is_sub}};
  assign adder_sum = adder_a + adder_b + {{`EX_XLEN{1'b0}}, is_sub};

  // Top bit of the widened difference is a < b
  assign is_lt = adder_sum[`EX_XLEN];
  assign is_eq = (operand_a_i == operand_b_i);

  ////////////////////
  // Comparison
  ////////////////////

  always_comb begin
    unique case (operator_i)
      ex_pkg::ALU_EQ:   cmp_result_o = is_eq;
      ex_pkg::ALU_NE:   cmp_result_o = !is_eq;
      ex_pkg::ALU_SLT,
      ex_pkg::ALU_SLTU,
      ex_pkg::ALU_LT,
      ex_pkg::ALU_LTU:  cmp_result_o = is_lt;
      ex_pkg::ALU_GE,
      ex_pkg::ALU_GEU:  cmp_result_o = !is_lt;
      // Arithmetic, logic and shifts carry no decision
      default:          cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////
  // Result select
  ////////////////////

  // Shift amount from the low five bits of b
  assign shamt = operand_b_i[4:0];

  always_comb begin
    unique case (operator_i)
      ex_pkg::ALU_ADD,
      ex_pkg::ALU_SUB: result_o = adder_sum[`EX_XLEN-1:0];
      ex_pkg::ALU_AND: result_o = operand_a_i & operand_b_i;
      ex_pkg::ALU_OR:  result_o = operand_a_i | operand_b_i;
      ex_pkg::ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      ex_pkg::ALU_SLL: result_o = operand_a_i << shamt;
      ex_pkg::ALU_SRL: result_o = operand_a_i >> shamt;
      ex_pkg::ALU_SRA: result_o = $signed(operand_a_i) >>> shamt;
      // Compares return the flag in bit 0
      default:         result_o = {{(`EX_XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

// File: hdl/ex_mult.sv
`include "ex_consts.svh"

module ex_mult (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            enable_i,
  input  ex_pkg::mul_op_e operator_i,
  input  ex_pkg::word_t   op_a_i,
  input  ex_pkg::word_t   op_b_i,
  input  logic            ex_ready_i,
  output ex_pkg::word_t   result_o,
  output logic            multicycle_o,
  output logic            ready_o
);

  ex_pkg::mul_state_e state_q;
  ex_pkg::mul_state_e state_d;

  logic high_op;
  logic start;
  logic a_sign;
  logic b_sign;

  // Partial product of 17 by 33 bits in a 50 bit field
  logic [`EX_HALF+`EX_XLEN+1:0] half_ext;
  logic [`EX_HALF+`EX_XLEN+1:0] op_b_ext;
  logic [`EX_HALF+`EX_XLEN+1:0] partial;

  // 64 bit product accumulator
  logic [2*`EX_XLEN-1:0] partial_sext;
  logic [2*`EX_XLEN-1:0] acc_d;
  logic [2*`EX_XLEN-1:0] acc_q;

  ex_pkg::word_t lo_product;

  assign high_op = (operator_i != ex_pkg::MUL_LO);
  assign start   = enable_i && high_op;

  // Only MULH treats its operands as signed
  assign a_sign = (operator_i == ex_pkg::MUL_H) && op_a_i[`EX_XLEN-1];
  assign b_sign = (operator_i == ex_pkg::MUL_H) && op_b_i[`EX_XLEN-1];

  ////////////////////
  // Partial products
  ////////////////////

  // Low half is always unsigned and the high half carries the sign
  assign half_ext = (state_q == ex_pkg::MUL_ACC) ?
                    {{(2*`EX_HALF+2){a_sign}}, op_a_i[`EX_XLEN-1:`EX_HALF]} :
                    {{(`EX_XLEN+2){1'b0}}, op_a_i[`EX_HALF-1:0]};
  assign op_b_ext = {{(`EX_HALF+2){b_sign}}, op_b_i};

  // One multiplier serves both halves
  assign partial = half_ext * op_b_ext;
  assign partial_sext = {{(`EX_XLEN-`EX_HALF-2){partial[`EX_HALF+`EX_XLEN+1]}}, partial};

  // Second step adds the high-half product one half-word up
  assign acc_d = (state_q == ex_pkg::MUL_ACC) ?
                 acc_q + {partial_sext[2*`EX_XLEN-`EX_HALF-1:0], {`EX_HALF{1'b0}}} :
                 partial_sext;

  always_ff @(posedge clk) begin
    if ((state_q == ex_pkg::MUL_IDLE && start) || state_q == ex_pkg::MUL_ACC) begin
      acc_q <= acc_d;
    end
  end

  // Single-cycle low word
  assign lo_product = op_a_i * op_b_i;

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ex_pkg::MUL_IDLE: if (start) state_d = ex_pkg::MUL_ACC;
      ex_pkg::MUL_ACC:  state_d = ex_pkg::MUL_DONE;
      // Hold the high word until the stage moves on
      ex_pkg::MUL_DONE: if (ex_ready_i) state_d = ex_pkg::MUL_IDLE;
      default:          state_d = ex_pkg::MUL_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ex_pkg::MUL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Busy on the issue cycle and the accumulate cycle
  assign ready_o = !((state_q == ex_pkg::MUL_IDLE) && start) &&
                   (state_q != ex_pkg::MUL_ACC);
  assign multicycle_o = (state_q != ex_pkg::MUL_IDLE);
  assign result_o = (state_q == ex_pkg::MUL_DONE) ? acc_q[2*`EX_XLEN-1:`EX_XLEN] : lo_product;

  // A high-word stall lasts at most the issue and accumulate cycles
  a_stall_two_cycles : assert property (@(posedge clk) disable iff (!rst_n)
    (!ready_o && !$past(ready_o)) |=> ready_o);

  // Back-pressure keeps the finished result in place
  a_done_held : assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == ex_pkg::MUL_DONE && !ex_ready_i) |=>
    (state_q == ex_pkg::MUL_DONE && $stable(result_o)));

endmodule

// File: hdl/ex_pkg.sv
`include "ex_consts.svh"

package ex_pkg;

  // Operand or result word
  typedef logic [`EX_XLEN-1:0] word_t;
  // Register file write address
  typedef logic [`EX_REG_AW-1:0] reg_addr_t;

  // ALU operations, arithmetic and logic first, then compares
  typedef enum logic [`EX_ALU_OP_W-1:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  // Low word signed, high word signed, high word unsigned
  typedef enum logic [`EX_MUL_OP_W-1:0] {
    MUL_LO = 2'd0,
    MUL_H  = 2'd1,
    MUL_HU = 2'd2
  } mul_op_e;

  // High-word multiply sequencing
  typedef enum logic [1:0] {
    MUL_IDLE = 2'd0,
    MUL_ACC  = 2'd1,
    MUL_DONE = 2'd2
  } mul_state_e;

endpackage

// File: hdl/ex_stage.sv
module ex_stage (
  input  logic              clk,
  input  logic              rst_n,

  // ALU operands from decode
  input  ex_pkg::alu_op_e   alu_operator_i,
  input  ex_pkg::word_t     alu_operand_a_i,
  input  ex_pkg::word_t     alu_operand_b_i,
  input  ex_pkg::word_t     alu_operand_c_i,
  input  logic              alu_en_i,

  // Multiplier operands
  input  ex_pkg::mul_op_e   mult_operator_i,
  input  ex_pkg::word_t     mult_operand_a_i,
  input  ex_pkg::word_t     mult_operand_b_i,
  input  logic              mult_en_i,

  // CSR and LSU
  input  logic              csr_access_i,
  input  ex_pkg::word_t     csr_rdata_i,
  input  logic              lsu_en_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,

  // Write addresses and control
  input  logic              branch_in_ex_i,
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  input  logic              wb_ready_i,

  // Branch outcome to fetch
  output ex_pkg::word_t     jump_target_o,
  output logic              branch_decision_o,
  output logic              mult_multicycle_o,

  // Forwarding port to decode
  output ex_pkg::word_t     regfile_alu_wdata_fw_o,
  output ex_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output logic              regfile_alu_we_fw_o,

  // Load write port to WB
  output ex_pkg::word_t     regfile_wdata_wb_o,
  output ex_pkg::reg_addr_t regfile_waddr_wb_o,
  output logic              regfile_we_wb_o,

  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  ex_pkg::word_t alu_result;
  ex_pkg::word_t mult_result;
  logic          mult_ready;

  // Target is computed in decode
  assign jump_target_o = alu_operand_c_i;

  ////////////////////
  // Processing units
  ////////////////////

  ex_alu u_alu (
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (branch_decision_o)
  );

  // Stage ready releases a finished high-word multiply
  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .multicycle_o (mult_multicycle_o),
    .ready_o      (mult_ready)
  );

  ////////////////////
  // Output side
  ////////////////////

  ex_writeback u_writeback (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .csr_rdata_i            (csr_rdata_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .mult_ready_i           (mult_ready),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .lsu_err_i              (lsu_err_i),
    .wb_ready_i             (wb_ready_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

// File: hdl/ex_writeback.sv
module ex_writeback (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              alu_en_i,
  input  logic              mult_en_i,
  input  logic              csr_access_i,
  input  logic              lsu_en_i,
  input  logic              branch_in_ex_i,
  input  ex_pkg::word_t     alu_result_i,
  input  ex_pkg::word_t     mult_result_i,
  input  ex_pkg::word_t     csr_rdata_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  input  logic              mult_ready_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  input  logic              wb_ready_i,
  input  logic              regfile_alu_we_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  output ex_pkg::word_t     regfile_alu_wdata_fw_o,
  output ex_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output logic              regfile_alu_we_fw_o,
  output ex_pkg::word_t     regfile_wdata_wb_o,
  output ex_pkg::reg_addr_t regfile_waddr_wb_o,
  output logic              regfile_we_wb_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  // All units downstream of decode can accept
  logic units_ready;

  logic              lsu_we_q;
  ex_pkg::reg_addr_t lsu_waddr_q;

  ////////////////////
  // Forwarding port
  ////////////////////

  // Later sources override earlier ones
  always_comb begin
    regfile_alu_wdata_fw_o = '0;
    if (alu_en_i) regfile_alu_wdata_fw_o = alu_result_i;
    if (mult_en_i) regfile_alu_wdata_fw_o = mult_result_i;
    if (csr_access_i) regfile_alu_wdata_fw_o = csr_rdata_i;
  end

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  ////////////////////
  // Stall levels
  ////////////////////

  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  // Branches resolve here and never wait for WB
  assign ex_ready_o = units_ready | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

  ////////////////////
  // EX/WB load port
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q    <= 1'b0;
      lsu_waddr_q <= '0;
    end else if (ex_valid_o) begin
      // Faulting loads never write back
      lsu_we_q <= regfile_we_i & ~lsu_err_i;
      if (regfile_we_i & ~lsu_err_i) begin
        lsu_waddr_q <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // Bubble into WB
      lsu_we_q <= 1'b0;
    end
  end

  assign regfile_we_wb_o    = lsu_we_q;
  assign regfile_waddr_wb_o = lsu_waddr_q;
  // Load data arrives with the WB cycle
  assign regfile_wdata_wb_o = lsu_rdata_i;

  // Decode issues to one result unit at a time
  a_fw_src_onehot : assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({alu_en_i, mult_en_i, csr_access_i}));

endmodule

// File: include/ex_consts.svh
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

////////////////////
// Datapath widths
////////////////////

// Operand and result word
`define EX_XLEN 32

// Register file write address
`define EX_REG_AW 6

////////////////////
// Opcode widths
////////////////////

`define EX_ALU_OP_W 4
`define EX_MUL_OP_W 2

// One multiplicand half in the multicycle high-word multiply
`define EX_HALF 16

`endif

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_ex_stage -f sources.f -o tb_ex_stage \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_ex_stage | tee /dev/stderr | grep -qx "sim passed" \
  && exit 0 \
  || exit 1

// File: sources.f
+incdir+include
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_mult.sv
hdl/ex_writeback.sv
hdl/ex_stage.sv
testbench/tb_ex_stage.sv

// File: testbench/tb_ex_stage.sv
`include "ex_consts.svh"

module tb_ex_stage;

  timeunit 1ns;
  timeprecision 1ps;

  // Cycles allowed for a high-word multiply to finish
  localparam int MUL_TIMEOUT = 10;

  logic              clk;
  logic              rst_n;
  ex_pkg::alu_op_e   alu_operator_i;
  ex_pkg::word_t     alu_operand_a_i;
  ex_pkg::word_t     alu_operand_b_i;
  ex_pkg::word_t     alu_operand_c_i;
  logic              alu_en_i;
  ex_pkg::mul_op_e   mult_operator_i;
  ex_pkg::word_t     mult_operand_a_i;
  ex_pkg::word_t     mult_operand_b_i;
  logic              mult_en_i;
  logic              csr_access_i;
  ex_pkg::word_t     csr_rdata_i;
  logic              lsu_en_i;
  ex_pkg::word_t     lsu_rdata_i;
  logic              lsu_ready_ex_i;
  logic              lsu_err_i;
  logic              branch_in_ex_i;
  logic              regfile_alu_we_i;
  ex_pkg::reg_addr_t regfile_alu_waddr_i;
  logic              regfile_we_i;
  ex_pkg::reg_addr_t regfile_waddr_i;
  logic              wb_ready_i;

  ex_pkg::word_t     jump_target_o;
  logic              branch_decision_o;
  logic              mult_multicycle_o;
  ex_pkg::word_t     regfile_alu_wdata_fw_o;
  ex_pkg::reg_addr_t regfile_alu_waddr_fw_o;
  logic              regfile_alu_we_fw_o;
  ex_pkg::word_t     regfile_wdata_wb_o;
  ex_pkg::reg_addr_t regfile_waddr_wb_o;
  logic              regfile_we_wb_o;
  logic              ex_ready_o;
  logic              ex_valid_o;

  integer seed;
  int     errors;
  int     timeouts;

  // Reference copy of the EX/WB load port register
  logic              wb_we_q;
  ex_pkg::reg_addr_t wb_waddr_q;

  always #20 clk = ~clk;

  ex_stage u_ex_stage (.*);

  ////////////////////
  // Reference model
  ////////////////////

  function automatic logic cmp_model(input ex_pkg::alu_op_e op, input ex_pkg::word_t a,
                                     input ex_pkg::word_t b);
    logic res;
    case (op)
      ex_pkg::ALU_EQ:                    res = (a == b);
      ex_pkg::ALU_NE:                    res = (a != b);
      ex_pkg::ALU_SLT, ex_pkg::ALU_LT:   res = ($signed(a) < $signed(b));
      ex_pkg::ALU_SLTU, ex_pkg::ALU_LTU: res = (a < b);
      ex_pkg::ALU_GE:                    res = ($signed(a) >= $signed(b));
      ex_pkg::ALU_GEU:                   res = (a >= b);
      default:                           res = 1'b0;
    endcase
    return res;
  endfunction

  function automatic ex_pkg::word_t alu_model(input ex_pkg::alu_op_e op, input ex_pkg::word_t a,
                                              input ex_pkg::word_t b);
    ex_pkg::word_t res;
    case (op)
      ex_pkg::ALU_ADD: res = a + b;
      ex_pkg::ALU_SUB: res = a - b;
      ex_pkg::ALU_AND: res = a & b;
      ex_pkg::ALU_OR:  res = a | b;
      ex_pkg::ALU_XOR: res = a ^ b;
      ex_pkg::ALU_SLL: res = a << b[4:0];
      ex_pkg::ALU_SRL: res = a >> b[4:0];
      ex_pkg::ALU_SRA: res = $signed(a) >>> b[4:0];
      // Set-less-than and branch compares give 0 or 1
      default:         res = {{(`EX_XLEN-1){1'b0}}, cmp_model(op, a, b)};
    endcase
    return res;
  endfunction

  // Full 64 bit product, unsigned only for MULHU
  function automatic logic [2*`EX_XLEN-1:0] mul_model(input ex_pkg::mul_op_e op,
                                                      input ex_pkg::word_t a,
                                                      input ex_pkg::word_t b);
    logic [2*`EX_XLEN-1:0] ea;
    logic [2*`EX_XLEN-1:0] eb;
    if (op == ex_pkg::MUL_HU) begin
      ea = {{`EX_XLEN{1'b0}}, a};
      eb = {{`EX_XLEN{1'b0}}, b};
    end else begin
      ea = {{`EX_XLEN{a[`EX_XLEN-1]}}, a};
      eb = {{`EX_XLEN{b[`EX_XLEN-1]}}, b};
    end
    return ea * eb;
  endfunction

  ////////////////////
  // Helpers
  ////////////////////

  // Inputs change shortly after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic drive_idle();
    alu_operator_i      = ex_pkg::ALU_ADD;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_operand_c_i     = '0;
    alu_en_i            = 1'b0;
    mult_operator_i     = ex_pkg::MUL_LO;
    mult_operand_a_i    = '0;
    mult_operand_b_i    = '0;
    mult_en_i           = 1'b0;
    csr_access_i        = 1'b0;
    csr_rdata_i         = '0;
    lsu_en_i            = 1'b0;
    lsu_rdata_i         = '0;
    lsu_ready_ex_i      = 1'b1;
    lsu_err_i           = 1'b0;
    branch_in_ex_i      = 1'b0;
    regfile_alu_we_i    = 1'b0;
    regfile_alu_waddr_i = '0;
    regfile_we_i        = 1'b0;
    regfile_waddr_i     = '0;
    wb_ready_i          = 1'b1;
  endtask

  task automatic randomize_alu();
    logic [31:0] r;
    r = $random(seed);
    alu_operator_i  = ex_pkg::alu_op_e'(r[3:0]);
    alu_operand_a_i = $random(seed);
    alu_operand_b_i = $random(seed);
    // Equal operands now and then so EQ and NE see both outcomes
    if (r[5:4] == 2'b00) alu_operand_b_i = alu_operand_a_i;
    alu_operand_c_i = $random(seed);
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %s exp=%h act=%h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %s exp=%h act=%h", name, exp, act);
    end
  endtask

  // Issue a high-word multiply, optionally with WB back-pressure once it is done
  task automatic mul_high(input ex_pkg::mul_op_e op, input ex_pkg::word_t a,
                          input ex_pkg::word_t b, input int stall_cycles);
    logic [2*`EX_XLEN-1:0] prod;
    ex_pkg::word_t         exp_hi;
    int                    cyc;
    prod   = mul_model(op, a, b);
    exp_hi = prod[2*`EX_XLEN-1:`EX_XLEN];
    cyc    = 0;
    next_cycle();
    drive_idle();
    mult_en_i        = 1'b1;
    mult_operator_i  = op;
    mult_operand_a_i = a;
    mult_operand_b_i = b;
    wb_ready_i       = (stall_cycles == 0);
    @(negedge clk);
    if (stall_cycles == 0) begin
      while (ex_ready_o !== 1'b1 && cyc < MUL_TIMEOUT) begin
        check_bit("mult_multicycle_o", cyc != 0, mult_multicycle_o);
        @(negedge clk);
        cyc++;
      end
      if (ex_ready_o !== 1'b1) begin
        timeouts++;
        $display("Timed out waiting for ex_ready_o after a high-word multiply");
      end else if (cyc != 2) begin
        errors++;
        $display("FAIL ex_ready_o low cycles exp=%h act=%h", 2, cyc);
      end
    end else begin
      // Issue and accumulate cycles, WB already stalled
      repeat (2) begin
        check_bit("ex_ready_o", 1'b0, ex_ready_o);
        check_bit("mult_multicycle_o", cyc != 0, mult_multicycle_o);
        @(negedge clk);
        cyc++;
      end
      // Result must sit still while WB holds off
      repeat (stall_cycles) begin
        check_bit("ex_ready_o", 1'b0, ex_ready_o);
        check_bit("mult_multicycle_o", 1'b1, mult_multicycle_o);
        check_word("regfile_alu_wdata_fw_o", exp_hi, regfile_alu_wdata_fw_o);
        @(negedge clk);
      end
      next_cycle();
      wb_ready_i = 1'b1;
      @(negedge clk);
    end
    check_bit("ex_ready_o", 1'b1, ex_ready_o);
    check_bit("mult_multicycle_o", 1'b1, mult_multicycle_o);
    check_word("regfile_alu_wdata_fw_o", exp_hi, regfile_alu_wdata_fw_o);
    next_cycle();
    drive_idle();
    @(negedge clk);
    // Back in idle
    check_bit("mult_multicycle_o", 1'b0, mult_multicycle_o);
  endtask

  // Random stall inputs against the ready/valid rules and the load port register
  task automatic stall_rules(input int n);
    logic [31:0]           r;
    logic [2*`EX_XLEN-1:0] prod;
    logic                  exp_ready;
    logic                  exp_valid;
    ex_pkg::word_t         exp_fw;
    for (int i = 0; i < n; i++) begin
      next_cycle();
      r = $random(seed);
      drive_idle();
      randomize_alu();
      // At most one forwarding source, MUL_LO keeps the multiplier ready
      alu_en_i         = (r[1:0] == 2'd1);
      csr_access_i     = (r[1:0] == 2'd2);
      mult_en_i        = (r[1:0] == 2'd3);
      mult_operand_a_i = $random(seed);
      mult_operand_b_i = $random(seed);
      csr_rdata_i      = $random(seed);
      lsu_en_i         = r[2];
      lsu_ready_ex_i   = r[3] | r[4];
      wb_ready_i       = r[5] | r[6];
      branch_in_ex_i   = (r[9:7] == 3'd0);
      regfile_we_i     = r[10];
      lsu_err_i        = (r[12:11] == 2'd0);
      regfile_waddr_i  = r[18:13];
      lsu_rdata_i      = $random(seed);
      @(negedge clk);
      exp_ready = (lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
      exp_valid = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) &
                  lsu_ready_ex_i & wb_ready_i;
      prod = mul_model(mult_operator_i, mult_operand_a_i, mult_operand_b_i);
      if (csr_access_i) exp_fw = csr_rdata_i;
      else if (mult_en_i) exp_fw = prod[`EX_XLEN-1:0];
      else if (alu_en_i) exp_fw = alu_model(alu_operator_i, alu_operand_a_i, alu_operand_b_i);
      else exp_fw = '0;
      check_bit("ex_ready_o", exp_ready, ex_ready_o);
      check_bit("ex_valid_o", exp_valid, ex_valid_o);
      check_word("regfile_alu_wdata_fw_o", exp_fw, regfile_alu_wdata_fw_o);
      check_bit("regfile_we_wb_o", wb_we_q, regfile_we_wb_o);
      check_word("regfile_waddr_wb_o", 32'(wb_waddr_q), 32'(regfile_waddr_wb_o));
      check_word("regfile_wdata_wb_o", lsu_rdata_i, regfile_wdata_wb_o);
      // What the register takes on the coming edge
      if (exp_valid) begin
        wb_we_q = regfile_we_i & ~lsu_err_i;
        if (wb_we_q) wb_waddr_q = regfile_waddr_i;
      end else if (wb_ready_i) begin
        wb_we_q = 1'b0;
      end
    end
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    logic [31:0]           r;
    logic [2*`EX_XLEN-1:0] prod;
    seed       = 13;
    errors     = 0;
    timeouts   = 0;
    wb_we_q    = 1'b0;
    wb_waddr_q = '0;
    clk        = 1'b0;
    rst_n      = 1'b0;
    drive_idle();
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_bit("regfile_we_wb_o", 1'b0, regfile_we_wb_o);
    check_word("regfile_waddr_wb_o", 32'h0, 32'(regfile_waddr_wb_o));
    check_bit("mult_multicycle_o", 1'b0, mult_multicycle_o);

    // ALU results, compares and forwarding address
    for (int i = 0; i < 64; i++) begin
      next_cycle();
      drive_idle();
      randomize_alu();
      r = $random(seed);
      alu_en_i            = 1'b1;
      regfile_alu_we_i    = r[0];
      regfile_alu_waddr_i = r[6:1];
      @(negedge clk);
      check_word("regfile_alu_wdata_fw_o",
                 alu_model(alu_operator_i, alu_operand_a_i, alu_operand_b_i),
                 regfile_alu_wdata_fw_o);
      check_bit("regfile_alu_we_fw_o", regfile_alu_we_i, regfile_alu_we_fw_o);
      check_word("regfile_alu_waddr_fw_o", 32'(regfile_alu_waddr_i),
                 32'(regfile_alu_waddr_fw_o));
      check_bit("branch_decision_o",
                cmp_model(alu_operator_i, alu_operand_a_i, alu_operand_b_i),
                branch_decision_o);
      check_word("jump_target_o", alu_operand_c_i, jump_target_o);
    end

    // Single-cycle low word
    for (int i = 0; i < 16; i++) begin
      next_cycle();
      drive_idle();
      mult_en_i        = 1'b1;
      mult_operand_a_i = $random(seed);
      mult_operand_b_i = $random(seed);
      @(negedge clk);
      prod = mul_model(ex_pkg::MUL_LO, mult_operand_a_i, mult_operand_b_i);
      check_bit("ex_ready_o", 1'b1, ex_ready_o);
      check_bit("mult_multicycle_o", 1'b0, mult_multicycle_o);
      check_word("regfile_alu_wdata_fw_o", prod[`EX_XLEN-1:0], regfile_alu_wdata_fw_o);
    end

    // High word, every fourth one under back-pressure
    for (int i = 0; i < 16; i++) begin
      r = $random(seed);
      if (r[0]) mul_high(ex_pkg::MUL_H, $random(seed), $random(seed), (i % 4 == 1) ? 3 : 0);
      else mul_high(ex_pkg::MUL_HU, $random(seed), $random(seed), (i % 4 == 1) ? 3 : 0);
    end

    // CSR read data on the forwarding port
    for (int i = 0; i < 8; i++) begin
      next_cycle();
      drive_idle();
      csr_access_i = 1'b1;
      csr_rdata_i  = $random(seed);
      @(negedge clk);
      check_word("regfile_alu_wdata_fw_o", csr_rdata_i, regfile_alu_wdata_fw_o);
    end

    stall_rules(128);

    next_cycle();
    drive_idle();
    @(negedge clk);
    $display("Checks done with %0d errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
